//--- Makefile
VERILATOR ?= verilator
TOP       ?= backend_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/backend_assertions.sv
`timescale 1ns/1ps

module backend_assertions (
    input logic                      clk,
    input logic                      arst_n_i,
    input logic                      psel_i, penable_i, pwrite_i, pready_i,
    input logic [pipe_pkg::XLEN-1:0] paddr_i, pwdata_i,
    input logic                      flush_i, stall_i, inst_ready_i
);
    bit   setup_bad = 1'b0;
    bit   hold_bad  = 1'b0;
    bit   flush_bad = 1'b0;
    bit   ready_bad = 1'b0;
    logic failed;

    assign failed = setup_bad | hold_bad | flush_bad | ready_bad;

    // access phase only after a setup cycle
    a_setup: assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(penable_i) |-> (psel_i && $past(psel_i)))
        else begin
            $error("penable rose without a setup cycle");
            setup_bad = 1'b1;
        end

    a_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        (psel_i && penable_i && !pready_i) |=> (psel_i && penable_i
            && $stable(paddr_i) && $stable(pwrite_i) && $stable(pwdata_i)))
        else begin
            $error("apb signals changed during wait state");
            hold_bad = 1'b1;
        end

    a_flush: assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_i |=> !flush_i)
        else begin
            $error("flush longer than one cycle");
            flush_bad = 1'b1;
        end

    // an open apb transfer pauses dispatch and the front end
    a_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
        (psel_i && !(penable_i && pready_i)) |-> (stall_i && !inst_ready_i))
        else begin
            $error("inst_ready high or no stall while an apb transfer is open");
            ready_bad = 1'b1;
        end

endmodule

bind backend backend_assertions u_assertions (
    .clk, .arst_n_i,
    .psel_i(psel_o), .penable_i(penable_o), .pwrite_i(pwrite_o), .pready_i,
    .paddr_i(paddr_o), .pwdata_i(pwdata_o),
    .flush_i(flush_o), .stall_i(stall), .inst_ready_i(inst_ready_o)
);

//--- bench/backend_tb.sv
`timescale 1ns/1ps

module backend_tb;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int PROG_LEN   = 30;
    localparam int RST_CYCLES = 16;

    logic              clk, arst_n_i, inst_valid_i, pready_i;
    logic [XLEN-1:0]   inst_i, pc_i, prdata_i;
    logic              inst_ready_o, flush_o, psel_o, penable_o, pwrite_o;
    logic [XLEN-1:0]   redirect_pc_o, paddr_o, pwdata_o, commit_data_o;
    logic              commit_valid_o, commit_we_o;
    logic [REG_AW-1:0] commit_rd_o;

    logic [XLEN-1:0] rom [32];
    logic [XLEN-1:0] mem [256];
    logic [XLEN-1:0] ref_mem [256];
    logic [XLEN-1:0] ref_regs [NREG];
    logic [XLEN-1:0] ref_pc, fe_pc, fe_target;
    // {we, rd, data} per retired instruction
    logic [36:0]     exp_commit [$];
    logic [XLEN-1:0] exp_target [$];
    logic [15:0]     lfsr_state;
    logic [1:0]      wait_left;
    logic            fetch_on, fe_flush, fe_take, saw_ready_low;

    backend UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string why);
        if (why != "") $display("Error: %s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        abort_run("");
    endtask

    function automatic logic [XLEN-1:0] encode(input op_e op, input int rd, rj, rk, imm);
        return {op, 4'(rd), 4'(rj), 4'(rk), 16'(imm)};
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hb400 : 16'h0000);
    endfunction

    // two lfsr bits give 0 to 3 wait cycles
    function automatic logic [1:0] draw_wait();
        logic [1:0] w;
        w = 2'b00;
        for (int i = 0; i < 2; i++) begin
            w = {lfsr_state[0], w[1]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return w;
    endfunction

    // architectural step by the isa rules
    function automatic void model_step();
        logic [XLEN-1:0]   ins, a, b, imm, res, nxt, addr;
        logic [REG_AW-1:0] rd;
        logic              we;
        op_e               op;
        ins  = rom[ref_pc[6:2]];
        op   = op_e'(ins[OP_MSB:OP_LSB]);
        rd   = ins[RD_LSB +: REG_AW];
        a    = ref_regs[ins[RJ_LSB +: REG_AW]];
        b    = ref_regs[ins[RK_LSB +: REG_AW]];
        imm  = {{(XLEN-IMM_W){ins[IMM_W-1]}}, ins[IMM_W-1:0]};
        addr = a + imm;
        we   = 1'b1;
        res  = '0;
        nxt  = ref_pc + 32'd4;
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_ADDI: res = addr;
            OP_LUI:  res = {ins[15:0], 16'h0000};
            OP_LD:   res = ref_mem[addr[9:2]];
            OP_ST: begin
                we = 1'b0;
                ref_mem[addr[9:2]] = b;
            end
            OP_BEQ, OP_BNE: begin
                we = 1'b0;
                if ((a == b) == (op == OP_BEQ)) begin
                    nxt = ref_pc + (imm << 2);
                    exp_target.push_back(nxt);
                end
            end
            default: we = 1'b0;
        endcase
        if (we && rd != '0) ref_regs[rd] = res;
        exp_commit.push_back({we, rd, res});
        ref_pc = nxt;
    endfunction

    task automatic load_program();
        rom[0]  = encode(OP_LUI,  1, 0, 0, 16'h1234);
        rom[1]  = encode(OP_ADDI, 1, 1, 0, 16'h5678);
        rom[2]  = encode(OP_ADDI, 2, 0, 0, -3);
        rom[3]  = encode(OP_ADD,  3, 1, 2, 0);
        rom[4]  = encode(OP_SUB,  4, 3, 1, 0);
        rom[5]  = encode(OP_AND,  5, 4, 3, 0);
        rom[6]  = encode(OP_OR,   6, 5, 1, 0);
        rom[7]  = encode(OP_XOR,  7, 6, 2, 0);
        rom[8]  = encode(OP_ADDI, 0, 7, 0, 5);
        rom[9]  = encode(OP_ADD,  8, 0, 7, 0);
        rom[10] = encode(OP_ADDI, 9, 0, 0, 16'h40);
        rom[11] = encode(OP_ST,   0, 9, 7, 0);
        rom[12] = encode(OP_ST,   0, 9, 3, 4);
        rom[13] = encode(OP_LD,  10, 9, 0, 0);
        rom[14] = encode(OP_ADD, 11, 10, 1, 0);
        rom[15] = encode(OP_LD,  12, 9, 0, 8);
        rom[16] = encode(OP_LD,  13, 9, 0, 4);
        rom[17] = encode(OP_XOR, 14, 13, 12, 0);
        rom[18] = encode(OP_BEQ,  0, 10, 7, 3);
        rom[19] = encode(OP_ADDI, 15, 0, 0, 1);
        rom[20] = encode(OP_ADDI, 15, 0, 0, 2);
        rom[21] = encode(OP_BNE,  0, 10, 7, 2);
        rom[22] = encode(OP_ADDI, 15, 0, 0, 3);
        rom[23] = encode(OP_BNE,  0, 15, 2, 2);
        rom[24] = encode(OP_ADDI, 15, 15, 0, 1);
        rom[25] = encode(OP_BEQ,  0, 1, 2, 2);
        rom[26] = encode(OP_ST,   0, 9, 14, -4);
        rom[27] = encode(OP_LD,   1, 9, 0, -4);
        rom[28] = encode(OP_ADD,  2, 1, 1, 0);
        rom[29] = encode(OP_NOP,  0, 0, 0, 0);
        rom[30] = '0;
        rom[31] = '0;
    endtask

    initial begin
        arst_n_i      = 1'b0;
        inst_valid_i  = 1'b0;
        inst_i        = '0;
        pc_i          = '0;
        prdata_i      = '0;
        pready_i      = 1'b0;
        fetch_on      = 1'b0;
        fe_pc         = '0;
        fe_target     = '0;
        fe_flush      = 1'b0;
        fe_take       = 1'b0;
        saw_ready_low = 1'b0;
        wait_left     = '0;
        lfsr_state    = 16'd37;
        load_program();
        for (int i = 0; i < 256; i++) begin
            mem[i]     = (32'(i) * 32'h01000193) ^ 32'hc0ffee00;
            ref_mem[i] = mem[i];
        end
        for (int i = 0; i < NREG; i++) ref_regs[i] = '0;
        ref_pc = '0;
        while (ref_pc < 32'(PROG_LEN * 4)) model_step();
        repeat (RST_CYCLES) @(posedge clk);
        #1 arst_n_i = 1'b1;
        // a few idle cycles before the front end starts
        repeat (4) @(posedge clk);
        fetch_on = 1'b1;
        while (exp_commit.size() != 0) @(negedge clk);
        repeat (8) @(negedge clk);
        if (exp_target.size() == 0 && saw_ready_low) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            abort_run("a taken branch never flushed, or inst_ready_o never went low");
        end
    end

    initial begin
        repeat (RST_CYCLES + PROG_LEN * 12) @(posedge clk);
        abort_run("timeout, the pipeline stopped retiring instructions");
    end

    // front end follows handshake and redirect
    always @(posedge clk) begin
        #1;
        if (fetch_on) begin
            if (fe_flush) fe_pc = fe_target;
            else if (fe_take) fe_pc = fe_pc + 32'd4;
            inst_valid_i = (fe_pc < 32'(PROG_LEN * 4));
            inst_i       = inst_valid_i ? rom[fe_pc[6:2]] : '0;
            pc_i         = fe_pc;
        end
    end

    // apb slave with random wait states
    always @(posedge clk) begin
        #1;
        pready_i = 1'b0;
        if (psel_o && !penable_o) begin
            wait_left = draw_wait();
        end else if (psel_o && penable_o) begin
            if (wait_left == 2'd0) begin
                pready_i = 1'b1;
                if (pwrite_o) mem[paddr_o[9:2]] = pwdata_o;
                else prdata_i = mem[paddr_o[9:2]];
            end else begin
                wait_left = wait_left - 2'd1;
            end
        end
    end

    always @(negedge clk) begin
        logic [36:0]     head;
        logic [XLEN-1:0] tgt;
        if (!fetch_on) begin
            assert (!commit_valid_o && !psel_o && !flush_o)
                else report_mismatch("commit, psel or flush high before any stimulus");
        end
        if (fetch_on && !inst_ready_o) saw_ready_low = 1'b1;
        assert (!UUT.u_assertions.failed)
            else abort_run("a bound protocol assertion failed");
        if (arst_n_i && flush_o) begin
            assert (exp_target.size() != 0)
                else abort_run("flush_o raised with no taken branch left");
            tgt = exp_target.pop_front();
            assert (redirect_pc_o == tgt)
                else report_mismatch($sformatf("redirect %h, expected %h", redirect_pc_o, tgt));
        end
        if (arst_n_i && commit_valid_o) begin
            assert (exp_commit.size() != 0)
                else abort_run("commit seen after the last expected instruction");
            head = exp_commit.pop_front();
            assert (commit_we_o == head[36] && (!head[36] ||
                    (commit_rd_o == head[35:32] && commit_data_o == head[31:0])))
                else report_mismatch($sformatf("commit we %b rd %0d data %h, expected %b %0d %h",
                    commit_we_o, commit_rd_o, commit_data_o, head[36], head[35:32], head[31:0]));
        end
        fe_flush  = flush_o;
        fe_target = redirect_pc_o;
        fe_take   = inst_valid_i && inst_ready_o;
    end

endmodule

//--- design/backend.sv
`timescale 1ns/1ps

module backend (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        inst_valid_i,
    input  logic [pipe_pkg::XLEN-1:0]   inst_i,
    input  logic [pipe_pkg::XLEN-1:0]   pc_i,
    output logic                        inst_ready_o,
    output logic                        flush_o,
    output logic [pipe_pkg::XLEN-1:0]   redirect_pc_o,
    output logic                        psel_o, penable_o, pwrite_o,
    output logic [pipe_pkg::XLEN-1:0]   paddr_o, pwdata_o,
    input  logic [pipe_pkg::XLEN-1:0]   prdata_i,
    input  logic                        pready_i,
    output logic                        commit_valid_o,
    output logic [pipe_pkg::REG_AW-1:0] commit_rd_o,
    output logic                        commit_we_o,
    output logic [pipe_pkg::XLEN-1:0]   commit_data_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // decode register
    logic              d_valid, d_we, d_load, d_store, d_branch, d_bne, d_imm_sel;
    logic [XLEN-1:0]   d_pc, d_imm;
    logic [REG_AW-1:0] d_rd, d_rj, d_rk;
    alu_op_e           d_alu_op;

    // dispatch register
    logic              x_valid, x_we, x_load, x_store, x_branch, x_bne, x_imm_sel;
    logic [XLEN-1:0]   x_pc, x_a, x_b, x_imm;
    logic [REG_AW-1:0] x_rd;
    alu_op_e           x_alu_op;

    // execute register
    logic              m_valid, m_we, m_load, m_store;
    logic [XLEN-1:0]   m_result, m_sdata;
    logic [REG_AW-1:0] m_rd;

    // forwarding, regfile and pause
    logic              ex_fwd_we, ex_is_load, mem_fwd_we, stall, mem_busy, wb_valid, wb_we;
    logic [REG_AW-1:0] ex_fwd_rd, mem_fwd_rd, ra1, ra2, wb_rd;
    logic [XLEN-1:0]   ex_fwd_data, mem_fwd_data, rd1, rd2, wb_data;

    decoder u_decoder (
        .clk, .arst_n_i,
        .inst_valid_i, .inst_i, .pc_i,
        .stall_i(stall), .flush_i(flush_o), .inst_ready_o,
        .d_valid_o(d_valid), .d_pc_o(d_pc), .d_alu_op_o(d_alu_op),
        .d_rd_o(d_rd), .d_rj_o(d_rj), .d_rk_o(d_rk), .d_imm_o(d_imm),
        .d_we_o(d_we), .d_load_o(d_load), .d_store_o(d_store),
        .d_branch_o(d_branch), .d_bne_o(d_bne), .d_imm_sel_o(d_imm_sel)
    );

    dispatch u_dispatch (
        .clk, .arst_n_i,
        .d_valid_i(d_valid), .d_pc_i(d_pc), .d_alu_op_i(d_alu_op),
        .d_rd_i(d_rd), .d_rj_i(d_rj), .d_rk_i(d_rk), .d_imm_i(d_imm),
        .d_we_i(d_we), .d_load_i(d_load), .d_store_i(d_store),
        .d_branch_i(d_branch), .d_bne_i(d_bne), .d_imm_sel_i(d_imm_sel),
        .ra1_o(ra1), .ra2_o(ra2), .rd1_i(rd1), .rd2_i(rd2),
        .ex_fwd_we_i(ex_fwd_we), .ex_fwd_rd_i(ex_fwd_rd),
        .ex_fwd_data_i(ex_fwd_data), .ex_is_load_i(ex_is_load),
        .mem_fwd_we_i(mem_fwd_we), .mem_fwd_rd_i(mem_fwd_rd),
        .mem_fwd_data_i(mem_fwd_data),
        .mem_busy_i(mem_busy), .flush_i(flush_o), .stall_o(stall),
        .x_valid_o(x_valid), .x_pc_o(x_pc), .x_alu_op_o(x_alu_op), .x_rd_o(x_rd),
        .x_a_o(x_a), .x_b_o(x_b), .x_imm_o(x_imm),
        .x_we_o(x_we), .x_load_o(x_load), .x_store_o(x_store),
        .x_branch_o(x_branch), .x_bne_o(x_bne), .x_imm_sel_o(x_imm_sel)
    );

    regfile u_regfile (
        .clk, .arst_n_i,
        .ra1_i(ra1), .ra2_i(ra2), .rd1_o(rd1), .rd2_o(rd2),
        .we_i(wb_we), .wa_i(wb_rd), .wd_i(wb_data)
    );

    execute u_execute (
        .clk, .arst_n_i,
        .x_valid_i(x_valid), .x_pc_i(x_pc), .x_alu_op_i(x_alu_op), .x_rd_i(x_rd),
        .x_a_i(x_a), .x_b_i(x_b), .x_imm_i(x_imm),
        .x_we_i(x_we), .x_load_i(x_load), .x_store_i(x_store),
        .x_branch_i(x_branch), .x_bne_i(x_bne), .x_imm_sel_i(x_imm_sel),
        .mem_busy_i(mem_busy),
        .ex_fwd_we_o(ex_fwd_we), .ex_fwd_rd_o(ex_fwd_rd),
        .ex_fwd_data_o(ex_fwd_data), .ex_is_load_o(ex_is_load),
        .flush_o, .redirect_pc_o,
        .m_valid_o(m_valid), .m_rd_o(m_rd),
        .m_we_o(m_we), .m_load_o(m_load), .m_store_o(m_store),
        .m_result_o(m_result), .m_sdata_o(m_sdata)
    );

    mem_stage u_mem_stage (
        .clk, .arst_n_i,
        .m_valid_i(m_valid), .m_rd_i(m_rd),
        .m_we_i(m_we), .m_load_i(m_load), .m_store_i(m_store),
        .m_result_i(m_result), .m_sdata_i(m_sdata),
        .psel_o, .penable_o, .pwrite_o, .paddr_o, .pwdata_o,
        .prdata_i, .pready_i,
        .mem_busy_o(mem_busy),
        .mem_fwd_we_o(mem_fwd_we), .mem_fwd_rd_o(mem_fwd_rd),
        .mem_fwd_data_o(mem_fwd_data),
        .wb_valid_o(wb_valid), .wb_we_o(wb_we), .wb_rd_o(wb_rd), .wb_data_o(wb_data)
    );

    // retire port mirrors the writeback register
    assign commit_valid_o = wb_valid;
    assign commit_we_o    = wb_we;
    assign commit_rd_o    = wb_rd;
    assign commit_data_o  = wb_data;

endmodule

//--- design/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        inst_valid_i,
    input  logic [pipe_pkg::XLEN-1:0]   inst_i,
    input  logic [pipe_pkg::XLEN-1:0]   pc_i,
    input  logic                        stall_i,
    input  logic                        flush_i,
    output logic                        inst_ready_o,
    output logic                        d_valid_o,
    output logic [pipe_pkg::XLEN-1:0]   d_pc_o,
    output isa_pkg::alu_op_e            d_alu_op_o,
    output logic [pipe_pkg::REG_AW-1:0] d_rd_o, d_rj_o, d_rk_o,
    output logic [pipe_pkg::XLEN-1:0]   d_imm_o,
    output logic                        d_we_o, d_load_o, d_store_o,
    output logic                        d_branch_o, d_bne_o, d_imm_sel_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    op_e     op;
    alu_op_e alu_op;
    logic    we, load, store, branch, imm_sel, use_rj, use_rk;

    assign op = op_e'(inst_i[OP_MSB:OP_LSB]);
    assign inst_ready_o = ~stall_i;

    always_comb begin
        case (op)
            OP_SUB:  alu_op = ALU_SUB;
            OP_AND:  alu_op = ALU_AND;
            OP_OR:   alu_op = ALU_OR;
            OP_XOR:  alu_op = ALU_XOR;
            OP_LUI:  alu_op = ALU_LUI;
            default: alu_op = ALU_ADD;
        endcase
    end

    // unused source fields read as r0 so they never match a hazard
    always_comb begin
        we      = 1'b0;
        load    = 1'b0;
        store   = 1'b0;
        branch  = 1'b0;
        imm_sel = 1'b0;
        use_rj  = 1'b1;
        use_rk  = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                we     = 1'b1;
                use_rk = 1'b1;
            end
            OP_ADDI: begin
                we      = 1'b1;
                imm_sel = 1'b1;
            end
            OP_LUI: begin
                we      = 1'b1;
                imm_sel = 1'b1;
                use_rj  = 1'b0;
            end
            OP_LD: begin
                we      = 1'b1;
                load    = 1'b1;
                imm_sel = 1'b1;
            end
            OP_ST: begin
                store   = 1'b1;
                imm_sel = 1'b1;
                use_rk  = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                branch = 1'b1;
                use_rk = 1'b1;
            end
            default: use_rj = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            d_valid_o <= 1'b0;
        end else if (flush_i) begin
            d_valid_o <= 1'b0;
        end else if (!stall_i) begin
            d_valid_o <= inst_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            d_pc_o      <= pc_i;
            d_alu_op_o  <= alu_op;
            d_rd_o      <= inst_i[RD_LSB +: REG_AW];
            d_rj_o      <= use_rj ? inst_i[RJ_LSB +: REG_AW] : '0;
            d_rk_o      <= use_rk ? inst_i[RK_LSB +: REG_AW] : '0;
            d_imm_o     <= {{(XLEN-IMM_W){inst_i[IMM_W-1]}}, inst_i[IMM_W-1:0]};
            d_we_o      <= we;
            d_load_o    <= load;
            d_store_o   <= store;
            d_branch_o  <= branch;
            d_bne_o     <= (op == OP_BNE);
            d_imm_sel_o <= imm_sel;
        end
    end

endmodule

//--- design/dispatch.sv
`timescale 1ns/1ps

module dispatch (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        d_valid_i,
    input  logic [pipe_pkg::XLEN-1:0]   d_pc_i,
    input  isa_pkg::alu_op_e            d_alu_op_i,
    input  logic [pipe_pkg::REG_AW-1:0] d_rd_i, d_rj_i, d_rk_i,
    input  logic [pipe_pkg::XLEN-1:0]   d_imm_i,
    input  logic                        d_we_i, d_load_i, d_store_i,
    input  logic                        d_branch_i, d_bne_i, d_imm_sel_i,
    output logic [pipe_pkg::REG_AW-1:0] ra1_o, ra2_o,
    input  logic [pipe_pkg::XLEN-1:0]   rd1_i, rd2_i,
    input  logic                        ex_fwd_we_i,
    input  logic [pipe_pkg::REG_AW-1:0] ex_fwd_rd_i,
    input  logic [pipe_pkg::XLEN-1:0]   ex_fwd_data_i,
    input  logic                        ex_is_load_i,
    input  logic                        mem_fwd_we_i,
    input  logic [pipe_pkg::REG_AW-1:0] mem_fwd_rd_i,
    input  logic [pipe_pkg::XLEN-1:0]   mem_fwd_data_i,
    input  logic                        mem_busy_i,
    input  logic                        flush_i,
    output logic                        stall_o,
    output logic                        x_valid_o,
    output logic [pipe_pkg::XLEN-1:0]   x_pc_o,
    output isa_pkg::alu_op_e            x_alu_op_o,
    output logic [pipe_pkg::REG_AW-1:0] x_rd_o,
    output logic [pipe_pkg::XLEN-1:0]   x_a_o, x_b_o, x_imm_o,
    output logic                        x_we_o, x_load_o, x_store_o,
    output logic                        x_branch_o, x_bne_o, x_imm_sel_o
);
    import pipe_pkg::*;

    logic            load_use;
    logic [XLEN-1:0] a_val, b_val;

    // youngest producer wins, the regfile covers writeback
    function automatic logic [XLEN-1:0] operand(input logic [REG_AW-1:0] ra,
                                                input logic [XLEN-1:0]   rf_val);
        if (ra != '0 && ex_fwd_we_i && ex_fwd_rd_i == ra) begin
            return ex_fwd_data_i;
        end
        if (ra != '0 && mem_fwd_we_i && mem_fwd_rd_i == ra) begin
            return mem_fwd_data_i;
        end
        return rf_val;
    endfunction

    assign ra1_o = d_rj_i;
    assign ra2_o = d_rk_i;

    always_comb begin
        a_val = operand(d_rj_i, rd1_i);
        b_val = operand(d_rk_i, rd2_i);
    end

    // load in execute has no data yet
    assign load_use = d_valid_i & ex_is_load_i & (ex_fwd_rd_i != '0)
                    & ((ex_fwd_rd_i == d_rj_i) | (ex_fwd_rd_i == d_rk_i));
    assign stall_o  = mem_busy_i | load_use;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            x_valid_o <= 1'b0;
        end else if (flush_i || (load_use && !mem_busy_i)) begin
            x_valid_o <= 1'b0;
        end else if (!mem_busy_i) begin
            x_valid_o <= d_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_o) begin
            x_pc_o      <= d_pc_i;
            x_alu_op_o  <= d_alu_op_i;
            x_rd_o      <= d_rd_i;
            x_a_o       <= a_val;
            x_b_o       <= b_val;
            x_imm_o     <= d_imm_i;
            x_we_o      <= d_we_i;
            x_load_o    <= d_load_i;
            x_store_o   <= d_store_i;
            x_branch_o  <= d_branch_i;
            x_bne_o     <= d_bne_i;
            x_imm_sel_o <= d_imm_sel_i;
        end
    end

endmodule

//--- design/execute.sv
`timescale 1ns/1ps

module execute (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        x_valid_i,
    input  logic [pipe_pkg::XLEN-1:0]   x_pc_i,
    input  isa_pkg::alu_op_e            x_alu_op_i,
    input  logic [pipe_pkg::REG_AW-1:0] x_rd_i,
    input  logic [pipe_pkg::XLEN-1:0]   x_a_i, x_b_i, x_imm_i,
    input  logic                        x_we_i, x_load_i, x_store_i,
    input  logic                        x_branch_i, x_bne_i, x_imm_sel_i,
    input  logic                        mem_busy_i,
    output logic                        ex_fwd_we_o,
    output logic [pipe_pkg::REG_AW-1:0] ex_fwd_rd_o,
    output logic [pipe_pkg::XLEN-1:0]   ex_fwd_data_o,
    output logic                        ex_is_load_o,
    output logic                        flush_o,
    output logic [pipe_pkg::XLEN-1:0]   redirect_pc_o,
    output logic                        m_valid_o,
    output logic [pipe_pkg::REG_AW-1:0] m_rd_o,
    output logic                        m_we_o, m_load_o, m_store_o,
    output logic [pipe_pkg::XLEN-1:0]   m_result_o, m_sdata_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [XLEN-1:0] op2, result;
    logic            taken;

    assign op2 = x_imm_sel_i ? x_imm_i : x_b_i;

    // loads and stores use the add path for their address
    always_comb begin
        case (x_alu_op_i)
            ALU_SUB: result = x_a_i - op2;
            ALU_AND: result = x_a_i & op2;
            ALU_OR:  result = x_a_i | op2;
            ALU_XOR: result = x_a_i ^ op2;
            ALU_LUI: result = op2 << 16;
            default: result = x_a_i + op2;
        endcase
    end

    assign taken = x_valid_i & x_branch_i & ((x_a_i == x_b_i) ^ x_bne_i);
    // branch waits in execute while memory is busy, so flush fires once
    assign flush_o       = taken & ~mem_busy_i;
    assign redirect_pc_o = x_pc_i + (x_imm_i << 2);

    assign ex_fwd_we_o   = x_valid_i & x_we_i;
    assign ex_fwd_rd_o   = x_rd_i;
    assign ex_fwd_data_o = result;
    assign ex_is_load_o  = x_valid_i & x_load_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            m_valid_o <= 1'b0;
        end else if (!mem_busy_i) begin
            m_valid_o <= x_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_busy_i) begin
            m_rd_o     <= x_rd_i;
            m_we_o     <= x_we_i;
            m_load_o   <= x_load_i;
            m_store_o  <= x_store_i;
            m_result_o <= result;
            m_sdata_o  <= x_b_i;
        end
    end

endmodule

//--- design/isa_pkg.sv
package isa_pkg;

    // instruction fields
    localparam int OP_MSB = 31;
    localparam int OP_LSB = 28;
    localparam int RD_LSB = 24;
    localparam int RJ_LSB = 20;
    localparam int RK_LSB = 16;
    localparam int IMM_W  = 16;

    // unknown codes decode as nop
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_ADDI = 4'h6,
        OP_LUI  = 4'h7,
        OP_LD   = 4'h8,
        OP_ST   = 4'h9,
        OP_BEQ  = 4'ha,
        OP_BNE  = 4'hb
    } op_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_LUI = 3'd5
    } alu_op_e;

endpackage

//--- design/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        m_valid_i,
    input  logic [pipe_pkg::REG_AW-1:0] m_rd_i,
    input  logic                        m_we_i, m_load_i, m_store_i,
    input  logic [pipe_pkg::XLEN-1:0]   m_result_i, m_sdata_i,
    output logic                        psel_o, penable_o, pwrite_o,
    output logic [pipe_pkg::XLEN-1:0]   paddr_o, pwdata_o,
    input  logic [pipe_pkg::XLEN-1:0]   prdata_i,
    input  logic                        pready_i,
    output logic                        mem_busy_o,
    output logic                        mem_fwd_we_o,
    output logic [pipe_pkg::REG_AW-1:0] mem_fwd_rd_o,
    output logic [pipe_pkg::XLEN-1:0]   mem_fwd_data_o,
    output logic                        wb_valid_o, wb_we_o,
    output logic [pipe_pkg::REG_AW-1:0] wb_rd_o,
    output logic [pipe_pkg::XLEN-1:0]   wb_data_o
);
    import pipe_pkg::*;

    apb_state_e      state, state_nxt;
    logic            mem_op, done;
    logic [XLEN-1:0] result;

    assign mem_op     = m_valid_i & (m_load_i | m_store_i);
    assign done       = (state == ACCESS) & pready_i;
    assign mem_busy_o = mem_op & ~done;
    assign result     = m_load_i ? prdata_i : m_result_i;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (mem_op) state_nxt = SETUP;
            SETUP:   state_nxt = ACCESS;
            ACCESS:  if (pready_i) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // execute register is held during the transfer, so the bus stays stable
    assign psel_o    = (state != IDLE);
    assign penable_o = (state == ACCESS);
    assign pwrite_o  = m_store_i;
    assign paddr_o   = m_result_i;
    assign pwdata_o  = m_sdata_i;

    // a load forwards only on its completing cycle
    assign mem_fwd_we_o   = m_valid_i & m_we_i & (~m_load_i | done);
    assign mem_fwd_rd_o   = m_rd_i;
    assign mem_fwd_data_o = result;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state      <= IDLE;
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
        end else begin
            state      <= state_nxt;
            wb_valid_o <= m_valid_i & ~mem_busy_o;
            wb_we_o    <= m_valid_i & m_we_i & ~mem_busy_o;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_busy_o) begin
            wb_rd_o   <= m_rd_i;
            wb_data_o <= result;
        end
    end

endmodule

//--- design/pipe_pkg.sv
package pipe_pkg;

    // data and address width
    localparam int XLEN   = 32;
    localparam int NREG   = 16;
    localparam int REG_AW = 4;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        SETUP  = 2'd1,
        ACCESS = 2'd2
    } apb_state_e;

endpackage

//--- design/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic [pipe_pkg::REG_AW-1:0] ra1_i, ra2_i,
    output logic [pipe_pkg::XLEN-1:0]   rd1_o, rd2_o,
    input  logic                        we_i,
    input  logic [pipe_pkg::REG_AW-1:0] wa_i,
    input  logic [pipe_pkg::XLEN-1:0]   wd_i
);
    import pipe_pkg::*;

    logic [XLEN-1:0] regs [NREG];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wa_i != '0) begin
            regs[wa_i] <= wd_i;
        end
    end

    // r0 hardwired, same-cycle write bypasses the array
    assign rd1_o = (ra1_i == '0) ? '0 : (we_i && wa_i == ra1_i) ? wd_i : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 : (we_i && wa_i == ra2_i) ? wd_i : regs[ra2_i];

endmodule

//--- filelist.f
design/isa_pkg.sv
design/pipe_pkg.sv
design/decoder.sv
design/regfile.sv
design/dispatch.sv
design/execute.sv
design/mem_stage.sv
design/backend.sv
bench/backend_assertions.sv
bench/backend_tb.sv
